/* project.f */
hdl/histPkg.sv
hdl/binSequencer.sv
hdl/histogramMemory.sv
hdl/peakTracker.sv
hdl/histPeakFinder.sv
tests/tbClock.sv
tests/resultChecker.sv
tests/histPeakFinderTb.sv

/* Makefile */
TOP := histPeakFinderTb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f project.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f project.f
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	test $$status -eq 0 && ! grep -q "test failed" sim.log

clean:
	rm -rf obj_dir sim.log

/* tests/histPeakFinderTb.sv */
`timescale 1ns/1ps

module histPeakFinderTb;

    localparam int passLen      = histPkg::acqCount * histPkg::pixelCount
                                * histPkg::samplesPerPixel;
    localparam int binsPerPixel = 64;
    localparam int topBase      = 4032;  // highest window lower bound
    localparam int measCount    = 7;     // four single tests, three noisy runs
    localparam int timeLimit    = measCount * (2 * passLen + 50) * 10 * 2;

    logic                 clk;
    logic                 combin_res;
    logic                 sampleStrobe;
    histPkg::stamp_t      sample;
    logic                 collecting;
    histPkg::peakStamps_t peakResults;
    logic                 resultValid;
    logic                 expPush;
    histPkg::peakStamps_t expValue;
    int                   expTest;
    logic                 runDone;
    int                   errorCount;
    int                   checkedCount;
    logic [31:0]          rngState;
    histPkg::stamp_t      stimBuf [2*passLen];  // coarse pass, then fine pass

    tbClock clockGen0 (.clk(clk), .combin_res(combin_res));

    histPeakFinder dut0 (
        .clk          (clk),
        .combin_res   (combin_res),
        .sampleStrobe (sampleStrobe),
        .sample       (sample),
        .collecting   (collecting),
        .peakResults  (peakResults),
        .resultValid  (resultValid)
    );

    resultChecker checker0 (
        .clk          (clk),
        .combin_res   (combin_res),
        .collecting   (collecting),
        .peakResults  (peakResults),
        .resultValid  (resultValid),
        .expPush      (expPush),
        .expValue     (expValue),
        .expTest      (expTest),
        .runDone      (runDone),
        .errorCount   (errorCount),
        .checkedCount (checkedCount)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int randBelow(input int n);
        rngState = xorshift(rngState);
        return int'(rngState[23:0]) % n;
    endfunction

    function automatic int pixelOf(input int k);
        return (k / histPkg::samplesPerPixel) % histPkg::pixelCount;
    endfunction

    // index of a sample among the 32 of its pixel in one pass
    function automatic int slotOf(input int k);
        return (k % passLen) / (histPkg::samplesPerPixel * histPkg::pixelCount)
             * histPkg::samplesPerPixel + k % histPkg::samplesPerPixel;
    endfunction

    function automatic histPkg::stamp_t spread(input int center, input int radius);
        int v;
        v = center + randBelow(2 * radius + 1) - radius;
        if (v < 0) v = 0;
        if (v > 4095) v = 4095;
        return histPkg::stamp_t'(v);
    endfunction

    // both passes over stimBuf, expected stamp per pixel
    function automatic histPkg::peakStamps_t referencePeaks();
        int hist [histPkg::pixelCount][binsPerPixel];
        int best [histPkg::pixelCount];
        int bestBin [histPkg::pixelCount];
        int base [histPkg::pixelCount];
        histPkg::peakStamps_t result;
        int p;
        int b;
        for (int passNo = 0; passNo < 2; passNo++) begin
            for (p = 0; p < histPkg::pixelCount; p++) begin
                best[p]    = 0;
                bestBin[p] = 0;
                for (b = 0; b < binsPerPixel; b++) hist[p][b] = 0;
            end
            for (int k = 0; k < passLen; k++) begin
                p = pixelOf(k);
                if (passNo == 0) b = int'(stimBuf[k]) / 64;  // top six bits
                else b = int'(stimBuf[passLen + k]) - base[p];
                if (b >= 0 && b < binsPerPixel) begin
                    hist[p][b]++;
                    if (hist[p][b] > best[p]) begin  // equal count later does not win
                        best[p]    = hist[p][b];
                        bestBin[p] = b;
                    end
                end
            end
            if (passNo == 0) begin
                for (p = 0; p < histPkg::pixelCount; p++) begin
                    base[p] = bestBin[p] * 64 - histPkg::halfWindow;
                    if (base[p] < 0) base[p] = 0;
                    if (base[p] > topBase) base[p] = topBase;
                end
            end
        end
        for (p = 0; p < histPkg::pixelCount; p++) begin
            result[p] = histPkg::stamp_t'(base[p] + bestBin[p]);
        end
        return result;
    endfunction

    // mode 0 clean, 1 edges, 2 ties, 3 outliers, 4 noise
    task automatic buildSamples(input int mode);
        int center [histPkg::pixelCount];
        int p;
        int n;
        int first;
        int second;
        int base;
        for (p = 0; p < histPkg::pixelCount; p++) begin
            case (mode)
                1: center[p] = (p < 2) ? 8 + p * 32 : 4040 + (p - 2) * 48;
                4: center[p] = 100 + randBelow(3896);
                default: center[p] = 200 + p * 1000 + randBelow(600);
            endcase
        end
        for (int k = 0; k < 2 * passLen; k++) begin
            p      = pixelOf(k);
            n      = slotOf(k);
            first  = 10 + p * 12 + p % 2;          // tie bin filled first
            second = first + ((p % 2 == 1) ? -1 : 1);
            base   = first * 64 - histPkg::halfWindow;
            case (mode)
                2: begin
                    if (k < passLen) begin
                        stimBuf[k] = spread(((n % 2 == 0) ? first : second) * 64 + 20, 0);
                    end else begin
                        stimBuf[k] = spread(base + ((n % 2 == (p / 2) % 2) ? 5 : 50), 0);
                    end
                end
                3: stimBuf[k] = (k >= passLen && n % 2 == 1)
                              ? spread((center[p] + 2048) % 4096, 0) : spread(center[p], 3);
                4: stimBuf[k] = (randBelow(4) == 0)
                              ? spread(randBelow(4096), 0) : spread(center[p], 5);
                default: stimBuf[k] = spread(center[p], 3);
            endcase
        end
    endtask

    task automatic runMeasurement(input int testId);
        int idx;
        expValue = referencePeaks();
        expTest  = testId;
        expPush  = 1'b1;
        @(posedge clk);
        #1;
        expPush = 1'b0;
        idx     = 0;
        while (idx < 2 * passLen) begin
            if (collecting) begin
                sampleStrobe = 1'b1;
                sample       = stimBuf[idx];
                idx++;
            end else begin
                sampleStrobe = 1'b0;  // gap between passes
            end
            @(posedge clk);
            #1;
        end
        sampleStrobe = 1'b0;
    endtask

    initial begin
        sampleStrobe = 1'b0;
        sample       = '0;
        expPush      = 1'b0;
        expValue     = '0;
        expTest      = 0;
        runDone      = 1'b0;
        rngState     = 32'h1c6e35a1;
        wait (combin_res === 1'b1);
        for (int m = 0; m < measCount; m++) begin
            buildSamples((m < 4) ? m : 4);
            runMeasurement(m);
        end
        wait (checkedCount == measCount);
        @(posedge clk);
        #1;
        runDone = 1'b1;
        #1;
        if (errorCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        #(timeLimit);
        $display("timeout: a result never arrived within %0d ns", timeLimit);
        $display("test failed");
        $finish;
    end

endmodule

/* tests/resultChecker.sv */
`timescale 1ns/1ps

module resultChecker (
    input  logic                 clk,
    input  logic                 combin_res,
    input  logic                 collecting,
    input  histPkg::peakStamps_t peakResults,
    input  logic                 resultValid,
    input  logic                 expPush,
    input  histPkg::peakStamps_t expValue,
    input  int                   expTest,
    input  logic                 runDone,
    output int                   errorCount,
    output int                   checkedCount
);

    histPkg::peakStamps_t expQueue [$];   // expected results in measurement order
    int                   testQueue [$];
    int                   gapLen;         // low cycles of collecting so far
    logic                 seenCollect;    // first pass after reset has begun

    function automatic string testName(input int id);
        case (id)
            0: return "cleanPeak";
            1: return "edgeClamp";
            2: return "tieRule";
            3: return "outOfWindow";
            default: return $sformatf("noiseRun%0d", id - 3);
        endcase
    endfunction

    always @(posedge clk) begin
        histPkg::peakStamps_t expected;
        int testId;
        if (!combin_res) begin
            if (resultValid || collecting || peakResults != '0) begin
                $display("outputs not cleared while reset is asserted");
                errorCount++;
            end
            gapLen      = 0;
            seenCollect = 1'b0;
        end else if (!collecting) begin
            gapLen++;
        end else begin
            // gap between two passes
            if (seenCollect && gapLen != 0 && gapLen != histPkg::switchCycles) begin
                $display("collecting was low for %0d cycles between passes, expected %0d",
                         gapLen, histPkg::switchCycles);
                errorCount++;
            end
            seenCollect = 1'b1;
            gapLen      = 0;
        end
        if (expPush) begin
            expQueue.push_back(expValue);
            testQueue.push_back(expTest);
        end
        if (resultValid) begin
            if (expQueue.size() == 0) begin
                $display("resultValid pulsed with no measurement outstanding");
                errorCount++;
            end else begin
                expected = expQueue.pop_front();
                testId   = testQueue.pop_front();
                checkedCount++;
                for (int p = 0; p < histPkg::pixelCount; p++) begin
                    if (peakResults[p] !== expected[p]) begin
                        $display("MISMATCH %s pixel %0d expected %0d actual %0d",
                                 testName(testId), p, expected[p], peakResults[p]);
                        errorCount++;
                    end
                end
            end
        end
    end

    always @(posedge runDone) begin
        $display("results checked: %0d, errors: %0d", checkedCount, errorCount);
    end

endmodule

/* tests/tbClock.sv */
`timescale 1ns/1ps

module tbClock (
    output logic clk,
    output logic combin_res
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        combin_res = 1'b0;
        repeat (4) @(posedge clk);  // four cycles in reset
        #1 combin_res = 1'b1;       // released clear of the edge
    end

endmodule

/* hdl/histPeakFinder.sv */
`timescale 1ns/1ps

module histPeakFinder (
    input  logic                 clk,
    input  logic                 combin_res,
    input  logic                 sampleStrobe,
    input  histPkg::stamp_t      sample,
    output logic                 collecting,
    output histPkg::peakStamps_t peakResults,
    output logic                 resultValid
);

    histPkg::binWrite_t    binWrite;     // sequencer to memory
    histPkg::countUpdate_t countUpdate;  // memory to tracker
    histPkg::peakBins_t    coarsePeaks;  // tracker back to sequencer
    histPkg::peakStamps_t  windowBase;   // fine window lower bounds

    binSequencer binSeq0 (
        .clk          (clk),
        .combin_res   (combin_res),
        .sampleStrobe (sampleStrobe),
        .sample       (sample),
        .coarsePeaks  (coarsePeaks),
        .collecting   (collecting),
        .windowBase   (windowBase),
        .binWrite     (binWrite)
    );

    histogramMemory histMem0 (
        .clk         (clk),
        .combin_res  (combin_res),
        .binWrite    (binWrite),
        .countUpdate (countUpdate)
    );

    peakTracker peakTrk0 (
        .clk         (clk),
        .combin_res  (combin_res),
        .countUpdate (countUpdate),
        .windowBase  (windowBase),
        .coarsePeaks (coarsePeaks),
        .peakResults (peakResults),
        .resultValid (resultValid)
    );

endmodule

/* hdl/peakTracker.sv */
`timescale 1ns/1ps

module peakTracker (
    input  logic                  clk,
    input  logic                  combin_res,
    input  histPkg::countUpdate_t countUpdate,
    input  histPkg::peakStamps_t  windowBase,
    output histPkg::peakBins_t    coarsePeaks,
    output histPkg::peakStamps_t  peakResults,
    output logic                  resultValid
);

    histPkg::count_t    maxCount [histPkg::pixelCount];  // running maximum
    histPkg::peakBins_t peakBin;                          // bin of that maximum
    histPkg::count_t    nextMax [histPkg::pixelCount];
    histPkg::peakBins_t nextBin;
    histPkg::peakBins_t fineBins;                         // held for the result add
    logic               passEnd;
    logic               resultPending;

    assign passEnd = countUpdate.valid && countUpdate.last;

    // strictly greater, so the first bin to reach the top count stays
    always_comb begin
        for (int p = 0; p < histPkg::pixelCount; p++) begin
            nextMax[p] = maxCount[p];
            nextBin[p] = peakBin[p];
            if (countUpdate.valid && countUpdate.hit
                    && (countUpdate.pixel == histPkg::pixelWidth'(p))
                    && (countUpdate.count > maxCount[p])) begin
                nextMax[p] = countUpdate.count;
                nextBin[p] = countUpdate.bin;
            end
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int p = 0; p < histPkg::pixelCount; p++) begin
                maxCount[p] <= '0;
            end
            peakBin       <= '0;
            coarsePeaks   <= '0;
            peakResults   <= '0;
            resultPending <= 1'b0;
            resultValid   <= 1'b0;
        end else begin
            resultPending <= passEnd && countUpdate.fine;
            resultValid   <= resultPending;
            if (resultPending) begin
                for (int p = 0; p < histPkg::pixelCount; p++) begin
                    peakResults[p] <= windowBase[p] + histPkg::stampWidth'(fineBins[p]);
                end
            end
            if (passEnd) begin
                // maxima start over for the next pass
                for (int p = 0; p < histPkg::pixelCount; p++) begin
                    maxCount[p] <= '0;
                end
                peakBin <= '0;
                if (!countUpdate.fine) begin
                    coarsePeaks <= nextBin;
                end
            end else begin
                for (int p = 0; p < histPkg::pixelCount; p++) begin
                    maxCount[p] <= nextMax[p];
                end
                peakBin <= nextBin;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (passEnd && countUpdate.fine) begin
            fineBins <= nextBin;  // zero for a pixel without hits
        end
    end

    assert property (@(posedge clk) disable iff (!combin_res)
        countUpdate.last |-> countUpdate.valid);

endmodule

/* hdl/histogramMemory.sv */
`timescale 1ns/1ps

module histogramMemory (
    input  logic                  clk,
    input  logic                  combin_res,
    input  histPkg::binWrite_t    binWrite,
    output histPkg::countUpdate_t countUpdate
);

    histPkg::count_t counters [histPkg::pixelCount][histPkg::binCount];

    // a cleared flag makes its counter read as zero
    logic [histPkg::pixelCount-1:0][histPkg::binCount-1:0] binValid;

    histPkg::count_t curCount;
    histPkg::count_t newCount;
    logic            doCount;

    assign doCount  = binWrite.valid && binWrite.hit;
    assign curCount = binValid[binWrite.pixel][binWrite.bin]
                    ? counters[binWrite.pixel][binWrite.bin] : '0;
    assign newCount = curCount + 1'b1;

    always_ff @(posedge clk) begin
        if (doCount) begin
            counters[binWrite.pixel][binWrite.bin] <= newCount;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binValid <= '0;
        end else if (binWrite.valid && binWrite.last) begin
            binValid <= '0;  // whole histogram gone for the next pass
        end else if (doCount) begin
            binValid[binWrite.pixel][binWrite.bin] <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            countUpdate <= '0;
        end else begin
            countUpdate.valid <= binWrite.valid;
            countUpdate.hit   <= doCount;
            countUpdate.pixel <= binWrite.pixel;
            countUpdate.bin   <= binWrite.bin;
            countUpdate.count <= doCount ? newCount : '0;  // misses report zero
            countUpdate.fine  <= binWrite.fine;
            countUpdate.last  <= binWrite.last;
        end
    end

    // a counter that wrapped would report a hit with count zero
    assert property (@(posedge clk) disable iff (!combin_res)
        (countUpdate.valid && countUpdate.hit) |-> (countUpdate.count != '0));

endmodule

/* hdl/binSequencer.sv */
`timescale 1ns/1ps

module binSequencer (
    input  logic                 clk,
    input  logic                 combin_res,
    input  logic                 sampleStrobe,
    input  histPkg::stamp_t      sample,
    input  histPkg::peakBins_t   coarsePeaks,
    output logic                 collecting,
    output histPkg::peakStamps_t windowBase,
    output histPkg::binWrite_t   binWrite
);

    histPkg::pass_t                    state;
    logic                              nextFine;   // pass that follows the gap
    logic [histPkg::switchWidth-1:0]    switchCnt;
    logic [histPkg::sampleIdxWidth-1:0] sampleIdx;
    logic [histPkg::acqIdxWidth-1:0]    acqIdx;
    histPkg::pixel_t                   pixelIdx;
    logic                              take;
    logic                              lastSlot;

    // first stage, captured sample
    logic            s1Valid;
    logic            s1Fine;
    logic            s1Last;
    histPkg::pixel_t s1Pixel;
    histPkg::stamp_t s1Sample;

    // second stage, bin address
    histPkg::stamp_t base;
    histPkg::stamp_t offset;
    logic            inWindow;
    histPkg::bin_t   slotBin;
    logic            slotHit;

    // coarse peak * 64 - halfWindow, kept inside 0 .. maxBase
    function automatic histPkg::stamp_t lowerBound(input histPkg::bin_t peak);
        logic [histPkg::stampWidth:0] start;
        logic [histPkg::stampWidth:0] low;
        start = {1'b0, peak, {(histPkg::stampWidth - histPkg::binWidth){1'b0}}};
        if (start < (histPkg::stampWidth + 1)'(histPkg::halfWindow)) begin
            return '0;
        end
        low = start - (histPkg::stampWidth + 1)'(histPkg::halfWindow);
        if (low > (histPkg::stampWidth + 1)'(histPkg::maxBase)) begin
            low = (histPkg::stampWidth + 1)'(histPkg::maxBase);
        end
        return low[histPkg::stampWidth-1:0];
    endfunction

    assign collecting = (state == histPkg::coarse) || (state == histPkg::fine);
    assign take       = sampleStrobe && collecting;
    assign lastSlot   = (sampleIdx == histPkg::sampleIdxWidth'(histPkg::samplesPerPixel - 1))
                     && (pixelIdx == histPkg::pixelWidth'(histPkg::pixelCount - 1))
                     && (acqIdx == histPkg::acqIdxWidth'(histPkg::acqCount - 1));

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state      <= histPkg::idle;
            nextFine   <= 1'b0;
            switchCnt  <= '0;
            sampleIdx  <= '0;
            pixelIdx   <= '0;
            acqIdx     <= '0;
            windowBase <= '0;
        end else begin
            case (state)
                histPkg::idle: state <= histPkg::coarse;
                histPkg::coarse, histPkg::fine: begin
                    if (take) begin
                        if (sampleIdx == histPkg::sampleIdxWidth'(histPkg::samplesPerPixel - 1)) begin
                            sampleIdx <= '0;
                            if (pixelIdx == histPkg::pixelWidth'(histPkg::pixelCount - 1)) begin
                                pixelIdx <= '0;
                                acqIdx   <= lastSlot ? '0 : acqIdx + 1'b1;
                            end else begin
                                pixelIdx <= pixelIdx + 1'b1;
                            end
                        end else begin
                            sampleIdx <= sampleIdx + 1'b1;
                        end
                        if (lastSlot) begin
                            state     <= histPkg::switching;
                            switchCnt <= '0;
                            nextFine  <= (state == histPkg::coarse);
                        end
                    end
                end
                histPkg::switching: begin
                    if (switchCnt == histPkg::switchWidth'(histPkg::switchCycles - 1)) begin
                        state <= nextFine ? histPkg::fine : histPkg::coarse;
                        if (nextFine) begin
                            for (int p = 0; p < histPkg::pixelCount; p++) begin
                                windowBase[p] <= lowerBound(coarsePeaks[p]);
                            end
                        end
                    end else begin
                        switchCnt <= switchCnt + 1'b1;
                    end
                end
                default: state <= histPkg::idle;
            endcase
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            s1Valid <= 1'b0;
            s1Fine  <= 1'b0;
            s1Last  <= 1'b0;
        end else begin
            s1Valid <= take;
            s1Fine  <= (state == histPkg::fine);
            s1Last  <= take && lastSlot;
        end
    end

    always_ff @(posedge clk) begin
        s1Sample <= sample;
        s1Pixel  <= pixelIdx;
    end

    assign base     = windowBase[s1Pixel];
    assign offset   = s1Sample - base;  // only meaningful when inside the window
    assign inWindow = (s1Sample >= base) && (offset < histPkg::stampWidth'(histPkg::binCount));
    assign slotBin  = s1Fine ? offset[histPkg::binWidth-1:0]
                             : s1Sample[histPkg::stampWidth-1 -: histPkg::binWidth];
    assign slotHit  = !s1Fine || inWindow;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binWrite <= '0;
        end else begin
            binWrite.valid <= s1Valid;
            binWrite.hit   <= s1Valid && slotHit;
            binWrite.pixel <= s1Pixel;
            binWrite.bin   <= slotBin;
            binWrite.fine  <= s1Fine;
            binWrite.last  <= s1Last;
        end
    end

    // slot leaves two edges after it was taken in a sampling state
    assert property (@(posedge clk) disable iff (!combin_res)
        binWrite.valid |-> ($past(state, 2) inside {histPkg::coarse, histPkg::fine}));

    // dropped strobes leave the slot counters where they are
    assert property (@(posedge clk) disable iff (!combin_res)
        !collecting |=> ($stable(sampleIdx) && $stable(pixelIdx) && $stable(acqIdx)));

endmodule

/* hdl/histPkg.sv */
package histPkg;

    // sizes
    localparam int stampWidth      = 12;
    localparam int binWidth        = 6;
    localparam int binCount        = 1 << binWidth;  // 64 bins per pixel
    localparam int pixelCount      = 4;
    localparam int pixelWidth      = $clog2(pixelCount);
    localparam int samplesPerPixel = 4;
    localparam int acqCount        = 8;
    localparam int countWidth      = 8;               // holds 32 with room to spare
    localparam int switchCycles    = 4;
    localparam int halfWindow      = 32;

    // counter widths inside the sequencer
    localparam int sampleIdxWidth  = $clog2(samplesPerPixel);
    localparam int acqIdxWidth     = $clog2(acqCount);
    localparam int switchWidth     = $clog2(switchCycles);

    // highest window base, so base + 63 stays inside the stamp range
    localparam int maxBase         = (1 << stampWidth) - binCount;

    typedef logic [stampWidth-1:0] stamp_t;
    typedef logic [binWidth-1:0]   bin_t;
    typedef logic [pixelWidth-1:0] pixel_t;
    typedef logic [countWidth-1:0] count_t;

    typedef bin_t   [pixelCount-1:0] peakBins_t;    // coarse peak per pixel
    typedef stamp_t [pixelCount-1:0] peakStamps_t;  // one stamp per pixel

    typedef enum logic [1:0] {
        idle,
        coarse,
        switching,
        fine
    } pass_t;

    // sequencer to memory
    typedef struct packed {
        logic   valid;
        logic   hit;    // slot is counted
        pixel_t pixel;
        bin_t   bin;
        logic   fine;   // slot belongs to the fine pass
        logic   last;   // final slot of the pass
    } binWrite_t;

    // memory to tracker
    typedef struct packed {
        logic   valid;
        logic   hit;
        pixel_t pixel;
        bin_t   bin;
        count_t count;  // value after the increment
        logic   fine;
        logic   last;
    } countUpdate_t;

endpackage
